/* common/bbcPkg.sv */
package bbcPkg;

	// Processor side
	typedef logic [15:0] cpuAddrT;
	typedef logic [7:0] byteT;

	// Video side
	typedef logic [14:0] vidAddrT;
	typedef logic [13:0] frameAddrT;

	// Paged ROM
	typedef logic [3:0] romBankT;

	// os flag, bank, 14 offset bits
	typedef logic [18:0] romAddrT;

	// Active low, bit 0 CRTC up to bit 9 Tube
	typedef logic [9:0] chipSelT;

	typedef logic [3:0] phaseT;

	// Strobe phases of the 16 MHz counter
	// RAM slots at 4 MHz, processor at 2 MHz, slow I/O at 1 MHz
	localparam phaseT ramSlotPhase = 4'd3;
	localparam phaseT procPhase = 4'd7;
	localparam phaseT ioPhase = 4'd15;

endpackage

/* src/clockEnables.sv */
module clockEnables import bbcPkg::*; (
	input  logic CLK,
	input  logic arstN,
	output logic ramEn,
	output logic procEn,
	output logic ioEn
);

	phaseT phase;
	phaseT nextPhase;

	assign nextPhase = phaseT'(phase + 1'b1);

	// Strobes decode the next phase so they are high together with it
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			phase <= '0;
			ramEn <= 1'b0;
			procEn <= 1'b0;
			ioEn <= 1'b0;
		end else begin
			phase <= nextPhase;
			ramEn <= (nextPhase[1:0] == ramSlotPhase[1:0]);
			procEn <= (nextPhase[2:0] == procPhase[2:0]);
			ioEn <= (nextPhase == ioPhase);
		end
	end

endmodule

/* src/sheilaDecode.sv */
module sheilaDecode import bbcPkg::*; (
	input  cpuAddrT addr,
	output logic    sheila,
	output logic    osBank,
	output logic    auxBank,
	output chipSelT nSel,
	output logic    slowAccess
);

	// Page FE is the memory mapped I/O
	assign sheila = (addr[15:8] == 8'hFE);

	// OS ROM covers C000 up, minus the I/O page
	assign osBank = (addr[15:14] == 2'b11) && !sheila;
	assign auxBank = (addr[15:14] == 2'b10);

	always_comb begin
		nSel = '1;
		if (sheila) begin
			casez (addr[7:0])
				8'b0000_0???: nSel = 10'h3FE;
				8'b0000_1???: nSel = 10'h3FD;
				8'b0010_????: nSel = 10'h3FB;
				8'b0011_????: nSel = 10'h3F7;
				8'b010?_????: nSel = 10'h3EF;
				8'b011?_????: nSel = 10'h3DF;
				8'b100?_????: nSel = 10'h3BF;
				8'b101?_????: nSel = 10'h37F;
				8'b110?_????: nSel = 10'h2FF;
				8'b111?_????: nSel = 10'h1FF;
				// 10 to 1F has no device
				default: nSel = '1;
			endcase
		end
	end

	// 1 MHz peripherals: CRTC, ACIA, both VIAs, ADC
	assign slowAccess = !(nSel[0] && nSel[1] && nSel[4] && nSel[5] && nSel[8]);

endmodule

/* src/busControl.sv */
module busControl import bbcPkg::*; (
	input  logic    CLK,
	input  logic    arstN,
	input  logic    ramEn,
	input  logic    procEn,
	input  logic    ioEn,
	input  logic    slowAccess,
	input  logic    halt,
	input  logic    rnw,
	input  cpuAddrT addr,
	input  logic    sheila,
	input  chipSelT nSel,
	input  byteT    ramData,
	input  byteT    romByte,
	input  byteT    periphData,
	output logic    cpuEn,
	output logic    vidRead,
	output logic    cpuRead,
	output logic    ramWrite,
	output logic    romSlot,
	output logic    bankWrite,
	output byteT    rdData
);

	logic cycleStart;
	logic slowCycle;
	logic ioAligned;
	logic stretched;
	logic slowEnd;

	// New address arrives at the cycle end edge, length is fixed one clock later
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			cycleStart <= 1'b1;
			slowCycle <= 1'b0;
			ioAligned <= 1'b0;
			stretched <= 1'b0;
		end else begin
			cycleStart <= cpuEn;
			if (cycleStart)
				slowCycle <= slowAccess;
			if (cpuEn) begin
				ioAligned <= ioEn;
				stretched <= 1'b0;
			end else if (procEn && slowCycle) begin
				stretched <= 1'b1;
			end
		end
	end

	// Slow cycle runs one full 1 MHz period from wherever it started
	assign slowEnd = stretched && (ioAligned ? ioEn : procEn);
	assign cpuEn = !halt && (slowCycle ? slowEnd : procEn);

	// Video owns the RAM slot that lines up with procEn
	assign vidRead = ramEn && procEn;
	assign romSlot = ramEn && !procEn;
	assign cpuRead = romSlot && rnw;
	assign ramWrite = romSlot && !rnw && !addr[15];

	assign bankWrite = procEn && !nSel[3] && !rnw;

	always_comb begin
		if (sheila)
			rdData = periphData;
		else if (addr[15])
			rdData = romByte;
		else
			rdData = ramData;
	end

endmodule

/* memory/memoryBanks.sv */
module memoryBanks import bbcPkg::*; #(
	parameter int ramAddrW = 15
) (
	input  logic    CLK,
	input  logic    arstN,
	input  logic    vidRead,
	input  logic    cpuRead,
	input  logic    ramWrite,
	input  logic    romSlot,
	input  logic    bankWrite,
	input  cpuAddrT addr,
	input  byteT    wrData,
	input  vidAddrT vidAddr,
	input  logic    osBank,
	input  logic    auxBank,
	input  byteT    romData,
	output byteT    ramData,
	output byteT    vData,
	output byteT    romByte,
	output romAddrT romAddr
);

	localparam int ramDepth = 2 ** ramAddrW;

	typedef logic [ramAddrW-1:0] ramIdxT;

	byteT ram [ramDepth];
	romBankT romBank;
	ramIdxT vidIdx;
	ramIdxT cpuIdx;

	// Model A only decodes the low 16 KB
	assign vidIdx = vidAddr[ramAddrW-1:0];
	assign cpuIdx = addr[ramAddrW-1:0];

	// One port, time shared between video and processor slots
	always_ff @(posedge CLK) begin
		if (vidRead)
			vData <= ram[vidIdx];
		else if (cpuRead)
			ramData <= ram[cpuIdx];
		else if (ramWrite)
			ram[cpuIdx] <= wrData;
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			romBank <= '0;
		else if (bankWrite)
			romBank <= wrData[3:0];
	end

	assign romAddr = {osBank, romBank, addr[13:0]};

	// ROM byte held for the rest of the processor cycle
	always_ff @(posedge CLK) begin
		if (romSlot && (osBank || auxBank))
			romByte <= romData;
	end

endmodule

/* src/screenAddress.sv */
module screenAddress import bbcPkg::*; (
	input  logic       CLK,
	input  logic       arstN,
	input  logic       ioEn,
	input  logic       latchStrobe,
	input  logic [2:0] latchAddr,
	input  logic       latchData,
	input  frameAddrT  frameAddr,
	input  logic [2:0] rowAddr,
	input  logic       txtMode,
	output vidAddrT    vidAddr,
	output byteT       latchBits
);

	logic [3:0] wrapOffset;
	logic [3:0] wrappedHigh;

	// Addressable latch driven from system VIA port B
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			latchBits <= '0;
		else if (ioEn && latchStrobe)
			latchBits[latchAddr] <= latchData;
	end

	// Screen size from latch bits 5:4 picks the wrap distance
	always_comb begin
		wrapOffset = 4'd0;
		if (frameAddr[12]) begin
			case (latchBits[5:4])
				2'b00: wrapOffset = 4'd8;
				2'b01: wrapOffset = 4'd12;
				2'b10: wrapOffset = 4'd6;
				2'b11: wrapOffset = 4'd11;
				default: wrapOffset = 4'd0;
			endcase
		end
	end

	// Modulo 16 keeps the address inside the top of RAM
	assign wrappedHigh = 4'(frameAddr[11:8] + wrapOffset);

	// Teletext lives in the last 1 KB
	always_comb begin
		if (txtMode)
			vidAddr = {5'b11111, frameAddr[9:0]};
		else
			vidAddr = {wrappedHigh, frameAddr[7:0], rowAddr};
	end

endmodule

/* debug/breakpointUnit.sv */
module breakpointUnit import bbcPkg::*; (
	input  logic    CLK,
	input  logic    arstN,
	input  logic    buttonEn,
	input  logic    procEn,
	input  logic    btnUp,
	input  logic    btnDown,
	input  logic    btnLeft,
	input  logic    btnRight,
	input  logic    btnStep,
	input  logic    setBreakpoint,
	input  logic    enBreakpoint,
	input  logic    sync,
	input  cpuAddrT addr,
	output cpuAddrT breakpoint,
	output logic    halt
);

	logic [3:0] btnNow;
	logic [3:0] btnPrev;
	logic [3:0] btnEdge;
	logic stepPrev;
	logic stepEdge;
	logic stepPulse;
	logic contPulse;
	logic [1:0] nibblePtr;
	logic [3:0] nibbleInc;
	logic [1:0] ptrInc;
	logic stop;

	// Order is up, down, left, right
	assign btnNow = {btnRight, btnLeft, btnDown, btnUp};
	assign btnEdge = {4{buttonEn}} & btnNow & ~btnPrev;

	// Step button sampled at the processor rate
	assign stepEdge = procEn && btnStep && !stepPrev;
	assign stepPulse = stepEdge && !setBreakpoint;
	assign contPulse = stepEdge && setBreakpoint;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			btnPrev <= '0;
			stepPrev <= 1'b0;
		end else begin
			if (buttonEn)
				btnPrev <= btnNow;
			if (procEn)
				stepPrev <= btnStep;
		end
	end

	// Down adds all ones, i.e. minus one
	assign nibbleInc = btnEdge[0] ? 4'h1 : {4{btnEdge[1]}};
	assign ptrInc = btnEdge[2] ? 2'd1 : {2{btnEdge[3]}};

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			breakpoint <= '0;
			nibblePtr <= '0;
		end else if (setBreakpoint) begin
			breakpoint[nibblePtr*4 +: 4] <= 4'(breakpoint[nibblePtr*4 +: 4] + nibbleInc);
			nibblePtr <= 2'(nibblePtr + ptrInc);
		end
	end

	// Stays stopped until a continue press
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			stop <= 1'b0;
		else if (procEn) begin
			if (stop)
				stop <= !contPulse;
			else
				stop <= enBreakpoint && (addr == breakpoint);
		end
	end

	// Only opcode fetches are held, a step lets one through
	assign halt = stop && sync && !stepPulse;

endmodule

/* src/bbcMemorySystem.sv */
module bbcMemorySystem import bbcPkg::*; #(
	parameter int ramAddrW = 15
) (
	input  logic       CLK,
	input  logic       arstN,
	input  cpuAddrT    addr,
	input  byteT       wrData,
	input  logic       rnw,
	input  logic       sync,
	input  byteT       periphData,
	input  byteT       romData,
	input  frameAddrT  frameAddr,
	input  logic [2:0] rowAddr,
	input  logic       txtMode,
	input  logic       latchStrobe,
	input  logic [2:0] latchAddr,
	input  logic       latchData,
	input  logic       buttonEn,
	input  logic       btnUp,
	input  logic       btnDown,
	input  logic       btnLeft,
	input  logic       btnRight,
	input  logic       btnStep,
	input  logic       setBreakpoint,
	input  logic       enBreakpoint,
	output logic       cpuEn,
	output byteT       rdData,
	output chipSelT    nSel,
	output logic       halt,
	output byteT       vData,
	output vidAddrT    vidAddr,
	output romAddrT    romAddr,
	output byteT       latchBits,
	output cpuAddrT    breakpoint
);

	logic ramEn, procEn, ioEn;
	logic sheila, osBank, auxBank, slowAccess;
	logic vidRead, cpuRead, ramWrite, romSlot, bankWrite;
	byteT ramData;
	byteT romByte;

	clockEnables clockEnables_inst (
		.CLK(CLK), .arstN(arstN), .ramEn(ramEn), .procEn(procEn), .ioEn(ioEn)
	);

	sheilaDecode sheilaDecode_inst (
		.addr(addr), .sheila(sheila), .osBank(osBank), .auxBank(auxBank),
		.nSel(nSel), .slowAccess(slowAccess)
	);

	busControl busControl_inst (
		.CLK(CLK), .arstN(arstN), .ramEn(ramEn), .procEn(procEn), .ioEn(ioEn),
		.slowAccess(slowAccess), .halt(halt), .rnw(rnw), .addr(addr), .sheila(sheila),
		.nSel(nSel), .ramData(ramData), .romByte(romByte), .periphData(periphData),
		.cpuEn(cpuEn), .vidRead(vidRead), .cpuRead(cpuRead), .ramWrite(ramWrite),
		.romSlot(romSlot), .bankWrite(bankWrite), .rdData(rdData)
	);

	memoryBanks #(.ramAddrW(ramAddrW)) memoryBanks_inst (
		.CLK(CLK), .arstN(arstN), .vidRead(vidRead), .cpuRead(cpuRead),
		.ramWrite(ramWrite), .romSlot(romSlot), .bankWrite(bankWrite), .addr(addr),
		.wrData(wrData), .vidAddr(vidAddr), .osBank(osBank), .auxBank(auxBank),
		.romData(romData), .ramData(ramData), .vData(vData), .romByte(romByte),
		.romAddr(romAddr)
	);

	screenAddress screenAddress_inst (
		.CLK(CLK), .arstN(arstN), .ioEn(ioEn), .latchStrobe(latchStrobe),
		.latchAddr(latchAddr), .latchData(latchData), .frameAddr(frameAddr),
		.rowAddr(rowAddr), .txtMode(txtMode), .vidAddr(vidAddr), .latchBits(latchBits)
	);

	// Debug buttons and breakpoint compare
	breakpointUnit breakpointUnit_inst (
		.CLK(CLK), .arstN(arstN), .buttonEn(buttonEn), .procEn(procEn),
		.btnUp(btnUp), .btnDown(btnDown), .btnLeft(btnLeft), .btnRight(btnRight),
		.btnStep(btnStep), .setBreakpoint(setBreakpoint), .enBreakpoint(enBreakpoint),
		.sync(sync), .addr(addr), .breakpoint(breakpoint), .halt(halt)
	);

endmodule

/* verification/bbcMemory_chk.sv */
module bbcMemoryChk (
	input logic CLK,
	input logic arstN,
	input logic cpuEn,
	input logic slowAccess,
	input logic vidRead,
	input logic cpuRead,
	input logic ramWrite
);

	timeunit 1ns;
	timeprecision 100ps;

	// Processor cycles are at least 8 clocks apart
	assert property (@(posedge CLK) disable iff (!arstN) cpuEn |=> !cpuEn [*7])
		else $error("cycle end less than 8 clocks after the previous one");

	// A slow peripheral holds the cycle for 16 clocks
	assert property (@(posedge CLK) disable iff (!arstN)
			cpuEn ##1 slowAccess |-> !cpuEn [*15])
		else $error("slow cycle ended early");

	// Next RAM slot is 4 clocks after a video slot
	assert property (@(posedge CLK) disable iff (!arstN)
			vidRead |=> !(vidRead || cpuRead || ramWrite) [*3])
		else $error("RAM access too soon after a video slot");

endmodule

bind busControl bbcMemoryChk bbcMemoryChk_inst (
	.CLK(CLK), .arstN(arstN), .cpuEn(cpuEn), .slowAccess(slowAccess),
	.vidRead(vidRead), .cpuRead(cpuRead), .ramWrite(ramWrite)
);

/* verification/tbBbcMemorySystem.sv */
module tbBbcMemorySystem;

	import bbcPkg::*;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int numTrans = 300;
	localparam int timeoutNs = (numTrans + 100) * 16 * 40 * 2;

	logic CLK, arstN, rnw, sync, txtMode, latchStrobe, latchData;
	logic buttonEn, btnStep, setBreakpoint, enBreakpoint;
	logic [3:0] btns;
	logic [2:0] rowAddr, latchAddr;
	cpuAddrT addr, breakpoint;
	byteT wrData, periphData, romData, rdData, vData, latchBits;
	frameAddrT frameAddr;
	chipSelT nSel;
	vidAddrT vidAddr;
	romAddrT romAddr;
	logic cpuEn, halt;

	// Behavioural model
	byteT modelRam [int];
	romBankT modelBank;
	byteT modelLatch;
	cpuAddrT curAddr;
	byteT curData;
	logic curRnw;
	logic gapValid;
	logic [31:0] mainState, periphState;
	int errors, checks, endCount;

	bbcMemorySystem #(.ramAddrW(15)) bbcMemorySystem_inst (
		.CLK(CLK), .arstN(arstN), .addr(addr), .wrData(wrData), .rnw(rnw), .sync(sync),
		.periphData(periphData), .romData(romData), .frameAddr(frameAddr),
		.rowAddr(rowAddr), .txtMode(txtMode), .latchStrobe(latchStrobe),
		.latchAddr(latchAddr), .latchData(latchData), .buttonEn(buttonEn),
		.btnUp(btns[0]), .btnDown(btns[1]), .btnLeft(btns[2]), .btnRight(btns[3]),
		.btnStep(btnStep), .setBreakpoint(setBreakpoint), .enBreakpoint(enBreakpoint),
		.cpuEn(cpuEn), .rdData(rdData), .nSel(nSel), .halt(halt), .vData(vData),
		.vidAddr(vidAddr), .romAddr(romAddr), .latchBits(latchBits),
		.breakpoint(breakpoint)
	);

	// ROM chips: bank plus low byte, top half for the OS
	assign romData = byteT'(romAddr[17:14]) + romAddr[7:0] + (romAddr[18] ? 8'h80 : 8'h00);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic chipSelT expSel(input cpuAddrT a);
		int lo;
		int bitNum;
		lo = a[7:0];
		if (a[15:8] != 8'hFE || (lo >= 16 && lo < 32))
			return '1;
		if (lo < 8) bitNum = 0;
		else if (lo < 16) bitNum = 1;
		else if (lo < 48) bitNum = 2;
		else if (lo < 64) bitNum = 3;
		else if (lo < 96) bitNum = 4;
		else if (lo < 128) bitNum = 5;
		else if (lo < 160) bitNum = 6;
		else if (lo < 192) bitNum = 7;
		else if (lo < 224) bitNum = 8;
		else bitNum = 9;
		return ~(chipSelT'(1) << bitNum);
	endfunction

	function automatic logic expSlow(input cpuAddrT a);
		chipSelT s;
		s = expSel(a);
		return !(s[0] && s[1] && s[4] && s[5] && s[8]);
	endfunction

	// Returns 0 when the value is unknown to the model
	function automatic logic expRead(input cpuAddrT a, output byteT v);
		v = '0;
		if (a[15:8] == 8'hFE) begin
			v = periphData;
			return 1'b1;
		end else if (a[15]) begin
			v = byteT'(modelBank) + a[7:0] + ((a[15:14] == 2'b11) ? 8'h80 : 8'h00);
			return 1'b1;
		end else if (modelRam.exists(int'(a))) begin
			v = modelRam[int'(a)];
			return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic vidAddrT expVid(input frameAddrT f, input logic [2:0] row,
			input logic txt, input logic [1:0] size);
		logic [3:0] off;
		logic [3:0] hi;
		off = 4'd0;
		if (f[12])
			off = (size == 2'b00) ? 4'd8 : (size == 2'b01) ? 4'd12 :
				(size == 2'b10) ? 4'd6 : 4'd11;
		hi = 4'(f[11:8] + off);
		return txt ? {5'b11111, f[9:0]} : {hi, f[7:0], row};
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// Finishes the current bus cycle and presents the next one
	task automatic runCycle(input cpuAddrT a, input byteT d, input logic r, input logic s);
		int gap;
		byteT v;
		logic osFlag;
		gap = 0;
		do begin
			@(negedge CLK);
			gap++;
		end while (!cpuEn && gap < 64);
		if (!cpuEn) begin
			errors++;
			$display("No cycle end within 64 clocks at %0t ns", $time);
		end
		if (gapValid)
			check(gap, expSlow(curAddr) ? 16 : 8, "cycle length");
		check(nSel, expSel(curAddr), "nSel");
		osFlag = (curAddr[15:14] == 2'b11) && (curAddr[15:8] != 8'hFE);
		check(romAddr, {osFlag, modelBank, curAddr[13:0]}, "ROM address");
		if (curRnw && expRead(curAddr, v))
			check(rdData, v, "read data");
		if (!curRnw && !curAddr[15])
			modelRam[int'(curAddr)] = curData;
		if (!curRnw && curAddr[15:4] == 12'hFE3)
			modelBank = curData[3:0];
		@(posedge CLK);
		addr <= a;
		wrData <= d;
		rnw <= r;
		sync <= s;
		curAddr = a;
		curData = d;
		curRnw = r;
		gapValid = 1'b1;
	endtask

	task automatic pressButton(input int idx);
		@(posedge CLK);
		btns[idx] <= 1'b1;
		@(posedge CLK);
		btns[idx] <= 1'b0;
		@(posedge CLK);
	endtask

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	always @(negedge CLK)
		if (cpuEn)
			endCount++;

	always @(posedge CLK) begin
		periphState = xorshift(periphState);
		periphData <= periphState[7:0];
	end

	initial begin
		#(timeoutNs);
		$display("Timeout: the run did not finish after %0d ns", timeoutNs);
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		cpuAddrT a;
		cpuAddrT target;
		vidAddrT va;
		int n;
		int startCount;
		arstN = 1'b0;
		addr = '0;
		wrData = '0;
		rnw = 1'b1;
		sync = 1'b0;
		periphData = '0;
		frameAddr = '0;
		rowAddr = '0;
		txtMode = 1'b0;
		latchStrobe = 1'b0;
		latchAddr = '0;
		latchData = 1'b0;
		buttonEn = 1'b1;
		btns = '0;
		btnStep = 1'b0;
		setBreakpoint = 1'b0;
		enBreakpoint = 1'b0;
		modelBank = '0;
		modelLatch = '0;
		curAddr = '0;
		curData = '0;
		curRnw = 1'b1;
		gapValid = 1'b0;
		mainState = 32'd97;
		periphState = xorshift(xorshift(32'd97));
		errors = 0;
		checks = 0;
		endCount = 0;
		repeat (8) @(posedge CLK);
		arstN <= 1'b1;

		// Random RAM, ROM and SHEILA traffic
		for (int i = 0; i < numTrans; i++) begin
			mainState = xorshift(mainState);
			r = mainState;
			case (r % 12)
				6: a = 16'h8000 | (r[31:16] & 16'h3FFF);
				7: a = 16'hC000 | (r[31:16] & 16'h3DFF);
				8: a = 16'hFE30 | r[19:16];
				9, 10: a = 16'hFE00 | r[23:16];
				11: a = 16'h8000 | (r[31:16] & 16'h7007);
				default: a = r[31:16] & 16'h7007;
			endcase
			runCycle(a, r[15:8], (r % 12 == 8 || r % 12 == 11) ? 1'b0 : r[4], r[5]);
		end

		// Latch writes and screen address mapping
		for (int i = 0; i < 20; i++) begin
			mainState = xorshift(mainState);
			r = mainState;
			@(posedge CLK);
			latchStrobe <= 1'b1;
			latchAddr <= r[2:0];
			latchData <= r[3];
			repeat (16) @(posedge CLK);
			latchStrobe <= 1'b0;
			modelLatch[r[2:0]] = r[3];
			frameAddr <= r[31:18];
			rowAddr <= r[6:4];
			txtMode <= (r[9:8] == 2'b00);
			@(negedge CLK);
			va = expVid(r[31:18], r[6:4], r[9:8] == 2'b00, modelLatch[5:4]);
			check(latchBits, modelLatch, "latch bits");
			check(vidAddr, va, "screen address");
			gapValid = 1'b0;
			runCycle({1'b0, va}, r[17:10], 1'b0, 1'b0);
			runCycle({1'b0, va}, 8'h00, 1'b1, 1'b0);
			repeat (16) @(posedge CLK);
			@(negedge CLK);
			check(vData, modelRam[int'(va)], "video data");
			gapValid = 1'b0;
		end

		// Breakpoint entry, nibble by nibble
		mainState = xorshift(mainState);
		target = mainState[31:16] & 16'h7007;
		@(posedge CLK);
		setBreakpoint <= 1'b1;
		for (int k = 0; k < 4; k++) begin
			n = (int'(target[k*4 +: 4]) + 2) % 16;
			repeat (n) pressButton(0);
			repeat (2) pressButton(1);
			pressButton(2);
		end
		// Right steps back to the top nibble
		pressButton(3);
		pressButton(0);
		@(negedge CLK);
		check(breakpoint, target + 16'h1000, "breakpoint top nibble");
		pressButton(1);
		pressButton(2);
		setBreakpoint <= 1'b0;
		@(negedge CLK);
		check(breakpoint, target, "breakpoint");

		@(posedge CLK);
		enBreakpoint <= 1'b1;
		gapValid = 1'b0;
		runCycle(target, 8'h00, 1'b1, 1'b1);
		runCycle(target ^ 16'h0001, 8'h00, 1'b1, 1'b1);
		startCount = endCount;
		repeat (64) @(posedge CLK);
		check(endCount - startCount, 0, "cycle ends while stopped");
		@(negedge CLK);
		check(halt, 1'b1, "halt while stopped");
		@(posedge CLK);

		// Step lets one cycle through
		btnStep <= 1'b1;
		repeat (24) @(posedge CLK);
		btnStep <= 1'b0;
		repeat (24) @(posedge CLK);
		check(endCount - startCount, 1, "cycle ends after step");

		// Continue
		setBreakpoint <= 1'b1;
		btnStep <= 1'b1;
		startCount = endCount;
		repeat (24) @(posedge CLK);
		btnStep <= 1'b0;
		setBreakpoint <= 1'b0;
		enBreakpoint <= 1'b0;
		repeat (24) @(posedge CLK);
		check(endCount - startCount >= 4, 1, "cycles resumed after continue");
		check(breakpoint, target, "breakpoint kept");
		@(negedge CLK);
		check(halt, 1'b0, "halt after continue");
		gapValid = 1'b0;
		for (int i = 0; i < 4; i++)
			runCycle(target, 8'h00, 1'b1, 1'b0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* tb.f */
common/bbcPkg.sv
src/clockEnables.sv
src/sheilaDecode.sv
src/busControl.sv
memory/memoryBanks.sv
src/screenAddress.sv
debug/breakpointUnit.sv
src/bbcMemorySystem.sv
verification/bbcMemory_chk.sv
verification/tbBbcMemorySystem.sv
